//--- all.f
verilog/apu_pkg.sv
verilog/apu_dispatch.sv
verilog/apu_exec_unit.sv
verilog/apu_subsys_top.sv
sim/apu_dispatch_chk.sv
sim/apu_subsys_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the APU subsystem testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
  -f all.f --top-module apu_subsys_tb -o apu_sim

./obj_dir/apu_sim > sim.log
cat sim.log

if grep -q "TESTBENCH FAILED" sim.log; then
  exit 1
fi
exit 0

//--- sim/apu_tests.txt
# class reg op_a op_b probe_reg probe_kind(0 none, 1 read, 2 write) exp_hazard probe_decoding
# One instruction per line, operands in hex, other columns decimal
1 1 00000005 00000007 1 1 0 1
2 2 00001234 00005678 2 1 1 1
3 3 00120034 00000056 3 2 1 1
2 4 ffff0003 00020001 4 2 1 1
3 5 abcd1111 00002222 5 1 1 1
3 6 00010002 00030004 6 1 1 1
2 7 12345678 9abcdef0 7 1 1 1
1 8 ffffffff 00000002 8 2 0 1
0 9 00000013 0000000b 9 1 1 1
0 10 00000100 80000000 10 2 1 1
0 11 deadbeef 00000000 11 1 1 1
3 12 0000ffff 0000ffff 12 1 1 1
2 13 00000003 00000005 13 1 0 0
1 14 00000010 00000020 60 1 0 1
0 15 00000007 00000006 15 2 1 1
1 16 7fffffff 00000001 16 1 0 1
3 17 00ff0100 00000200 17 2 1 1
3 18 00010001 00010001 60 2 0 1
2 19 00000002 00000003 19 2 1 1
1 20 00000001 00000001 20 1 0 1
2 21 80000000 00000002 21 2 0 0
0 22 00000003 000000ff 22 1 1 1
0 23 00000001 00000001 23 0 0 1
3 24 ffff0002 00000003 24 1 1 1
2 25 0000000a 0000000b 25 0 0 0

//--- sim/apu_subsys_tb.sv
// Testbench for the APU subsystem with file stimulus, result scoreboard and hazard probes
`timescale 1ns/1ps

module apu_subsys_tb;

  import apu_pkg::*;

  logic                    clk_i;
  logic                    rst_ni;
  logic                    issue_en_i;
  apu_req_t                issue_req_i;
  reg_addr_t               issue_waddr_i;
  logic                    is_decoding_i;
  reg_addr_t [2:0]         rd_regs_i;
  logic      [2:0]         rd_valid_i;
  reg_addr_t [1:0]         wr_regs_i;
  logic      [1:0]         wr_valid_i;
  logic                    stall_o, rd_dep_o, wr_dep_o, active_o;
  logic                    stall_type_o, stall_nack_o;
  logic                    wb_valid_o;
  reg_addr_t               wb_addr_o;
  apu_data_t               wb_data_o;

  // Test table from the data file
  int        t_lat[$], t_reg[$], t_preg[$], t_kind[$], t_exp[$], t_dec[$];
  apu_data_t t_a[$], t_b[$];
  int        ntests;
  int        limit;
  int        cycles;
  int        errors;
  int        num_wb;
  int        outstanding;
  int        cur_test;

  // Scoreboard in issue order
  int        exp_id[$];
  reg_addr_t exp_reg[$];
  apu_data_t exp_val[$];

  apu_subsys_top #(
    .NumRdPorts (3),
    .NumWrPorts (2)
  ) apu_subsys_top_inst (.*);

  always #4 clk_i = ~clk_i;

  // Result rules per latency class
  function automatic apu_data_t class_result(int lat, apu_data_t a, apu_data_t b);
    apu_data_t lo_prod;
    lo_prod = {16'h0000, a[15:0]} * {16'h0000, b[15:0]};
    case (lat)
      1:       return a + b;
      3:       return lo_prod + {16'h0000, a[31:16]};
      default: return a * b;
    endcase
  endfunction

  //////////////////////////////////////////////////
  // Timeout
  //////////////////////////////////////////////////

  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (cycles > limit) begin
      $display("Timeout after %0d cycles, results still outstanding: %0d", cycles, outstanding);
      $display("TESTBENCH FAILED");
      $finish;
    end
  end

  //////////////////////////////////////////////////
  // Monitor and scoreboard sampled mid-cycle
  //////////////////////////////////////////////////

  always @(negedge clk_i) begin
    if (rst_ni) begin
      if (active_o !== (outstanding != 0)) begin
        $display("FAIL %0t: active_o %b with %0d outstanding", $time, active_o, outstanding);
        errors++;
      end
      if (wb_valid_o) begin
        num_wb++;
        outstanding--;
        if (exp_id.size() == 0) begin
          $display("Write-back to reg %0d with nothing outstanding", wb_addr_o);
          errors++;
        end else if (wb_addr_o !== exp_reg[0] || wb_data_o !== exp_val[0]) begin
          $display("FAIL %0t: test %0d got reg %0d data %h, expected reg %0d data %h",
                   $time, exp_id[0], wb_addr_o, wb_data_o, exp_reg[0], exp_val[0]);
          errors++;
        end else begin
          $display("test %0d done: reg %0d data %h", exp_id[0], wb_addr_o, wb_data_o);
        end
        if (exp_id.size() != 0) begin
          void'(exp_id.pop_front());
          void'(exp_reg.pop_front());
          void'(exp_val.pop_front());
        end
      end
      // Accepted at the coming edge
      if (issue_en_i && !stall_o) begin
        outstanding++;
        exp_id.push_back(cur_test);
        exp_reg.push_back(issue_waddr_i);
        exp_val.push_back(class_result(issue_req_i.lat, issue_req_i.op_a, issue_req_i.op_b));
      end
    end
  end

  //////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////

  initial begin
    int        fd;
    int        n;
    int        f_lat, f_reg, f_preg, f_kind, f_exp, f_dec;
    apu_data_t f_a, f_b;
    string     line;
    logic      accepted;
    logic      first;
    logic      got;
    int        gap;

    clk_i = 1'b0;
    rst_ni = 1'b0;
    issue_en_i = 1'b0;
    issue_req_i = '0;
    issue_waddr_i = '0;
    is_decoding_i = 1'b0;
    rd_regs_i = '0;
    rd_valid_i = '0;
    wr_regs_i = '0;
    wr_valid_i = '0;
    cycles = 0;
    errors = 0;
    num_wb = 0;
    outstanding = 0;
    cur_test = 0;
    ntests = 0;
    limit = 1000;
    void'($urandom(82093));

    fd = $fopen("sim/apu_tests.txt", "r");
    if (fd == 0) begin
      $display("Cannot open sim/apu_tests.txt");
      errors++;
    end else begin
      while (!$feof(fd)) begin
        line = "";
        void'($fgets(line, fd));
        if (line.len() > 0 && line[0] != "#") begin
          n = $sscanf(line, "%d %d %h %h %d %d %d %d",
                      f_lat, f_reg, f_a, f_b, f_preg, f_kind, f_exp, f_dec);
          if (n == 8) begin
            t_lat.push_back(f_lat);
            t_reg.push_back(f_reg);
            t_a.push_back(f_a);
            t_b.push_back(f_b);
            t_preg.push_back(f_preg);
            t_kind.push_back(f_kind);
            t_exp.push_back(f_exp);
            t_dec.push_back(f_dec);
          end
        end
      end
      $fclose(fd);
      ntests = t_lat.size();
      limit = ntests * 48;
    end

    repeat (10) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(posedge clk_i);

    for (int i = 0; i < ntests; i++) begin
      cur_test = i;
      issue_en_i <= 1'b1;
      issue_req_i.lat <= apu_lat_t'(t_lat[i]);
      issue_req_i.op_a <= t_a[i];
      issue_req_i.op_b <= t_b[i];
      issue_waddr_i <= reg_addr_t'(t_reg[i]);
      accepted = 1'b0;
      first = 1'b1;
      while (!accepted) begin
        @(negedge clk_i);
        // Iterative class never issues while anything is outstanding
        if (first && active_o && t_lat[i] == 0 &&
            !(stall_o && (stall_type_o || stall_nack_o))) begin
          $display("FAIL %0t: test %0d class 0 issued while active without stall", $time, i);
          errors++;
        end
        first = 1'b0;
        accepted = !stall_o;
        @(posedge clk_i);
      end
      issue_en_i <= 1'b0;

      // Hazard probe in the cycle after acceptance
      is_decoding_i <= t_dec[i][0];
      rd_regs_i[0] <= reg_addr_t'(t_preg[i]);
      wr_regs_i[1] <= reg_addr_t'(t_preg[i]);
      rd_valid_i <= (t_kind[i] == 1) ? 3'b001 : 3'b000;
      wr_valid_i <= (t_kind[i] == 2) ? 2'b10 : 2'b00;
      @(negedge clk_i);
      got = (t_kind[i] == 1) ? rd_dep_o : (t_kind[i] == 2) ? wr_dep_o : (rd_dep_o | wr_dep_o);
      if (got !== t_exp[i][0]) begin
        $display("FAIL %0t: test %0d probe reg %0d hazard %b, expected %0d",
                 $time, i, t_preg[i], got, t_exp[i]);
        errors++;
      end
      @(posedge clk_i);
      is_decoding_i <= 1'b0;
      rd_valid_i <= '0;
      wr_valid_i <= '0;
      gap = $urandom_range(2, 0);
      repeat (gap) @(posedge clk_i);
    end

    // Drain then check that no register still reports a hazard
    while (outstanding != 0) begin
      @(negedge clk_i);
    end
    @(posedge clk_i);
    for (int i = 0; i < ntests; i++) begin
      is_decoding_i <= 1'b1;
      rd_regs_i[0] <= reg_addr_t'(t_reg[i]);
      wr_regs_i[0] <= reg_addr_t'(t_reg[i]);
      rd_valid_i <= 3'b001;
      wr_valid_i <= 2'b01;
      @(negedge clk_i);
      if (rd_dep_o || wr_dep_o || active_o) begin
        $display("FAIL %0t: reg %0d still blocked after drain", $time, t_reg[i]);
        errors++;
      end
      @(posedge clk_i);
    end
    is_decoding_i <= 1'b0;
    rd_valid_i <= '0;
    wr_valid_i <= '0;

    if (num_wb != ntests) begin
      $display("Write-back count %0d does not match %0d accepted tests", num_wb, ntests);
      errors++;
    end
    $display("%0d tests, %0d write-backs, %0d errors", ntests, num_wb, errors);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

//--- sim/apu_dispatch_chk.sv
// Bound assertions on issue dispatcher slot and request invariants
`timescale 1ns/1ps

module apu_dispatch_chk (
  input logic clk_i,
  input logic rst_ni,
  input logic resp_valid_i,
  input logic infl_vld_q,
  input logic wait_vld_q,
  input logic req_o,
  input logic stall_type_o
);

  // A result always belongs to some outstanding instruction
  resp_has_owner: assert property (@(posedge clk_i) disable iff (!rst_ni)
    resp_valid_i |-> (infl_vld_q | wait_vld_q))
    else $error("response with no outstanding instruction");

  // Waiting slot only fills behind the in-flight slot
  wait_needs_infl: assert property (@(posedge clk_i) disable iff (!rst_ni)
    wait_vld_q |-> infl_vld_q)
    else $error("waiting slot valid without in-flight slot");

  // Type stall blocks the request
  no_req_on_type_stall: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(req_o && stall_type_o))
    else $error("request raised during type stall");

endmodule

bind apu_dispatch apu_dispatch_chk apu_dispatch_chk_inst (
  .clk_i        (clk_i),
  .rst_ni       (rst_ni),
  .resp_valid_i (resp_valid_i),
  .infl_vld_q   (infl_vld_q),
  .wait_vld_q   (wait_vld_q),
  .req_o        (req_o),
  .stall_type_o (stall_type_o)
);

//--- verilog/apu_subsys_top.sv
// Top level joining the issue dispatcher and the accelerator unit
`timescale 1ns/1ps

module apu_subsys_top #(
  parameter int NumRdPorts = 3,
  parameter int NumWrPorts = 2
) (
  input  logic                                  clk_i,
  input  logic                                  rst_ni,
  // Issue port
  input  logic                                  issue_en_i,
  input  apu_pkg::apu_req_t                     issue_req_i,
  input  apu_pkg::reg_addr_t                    issue_waddr_i,
  // Hazard probes
  input  logic                                  is_decoding_i,
  input  apu_pkg::reg_addr_t [NumRdPorts-1:0]   rd_regs_i,
  input  logic               [NumRdPorts-1:0]   rd_valid_i,
  input  apu_pkg::reg_addr_t [NumWrPorts-1:0]   wr_regs_i,
  input  logic               [NumWrPorts-1:0]   wr_valid_i,
  // Status
  output logic                                  stall_o,
  output logic                                  rd_dep_o,
  output logic                                  wr_dep_o,
  output logic                                  active_o,
  output logic                                  stall_type_o,
  output logic                                  stall_nack_o,
  // Write-back
  output logic                                  wb_valid_o,
  output apu_pkg::reg_addr_t                    wb_addr_o,
  output apu_pkg::apu_data_t                    wb_data_o
);

  import apu_pkg::*;

  // Link between dispatcher and unit
  logic      apu_req;
  logic      apu_gnt;
  apu_resp_t apu_resp;

  apu_dispatch #(
    .NumRdPorts (NumRdPorts),
    .NumWrPorts (NumWrPorts)
  ) apu_dispatch_inst (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .issue_en_i    (issue_en_i),
    .lat_i         (issue_req_i.lat),
    .waddr_i       (issue_waddr_i),
    .is_decoding_i (is_decoding_i),
    .rd_regs_i     (rd_regs_i),
    .rd_valid_i    (rd_valid_i),
    .wr_regs_i     (wr_regs_i),
    .wr_valid_i    (wr_valid_i),
    .req_o         (apu_req),
    .gnt_i         (apu_gnt),
    .resp_valid_i  (apu_resp.valid),
    .stall_o       (stall_o),
    .stall_type_o  (stall_type_o),
    .stall_nack_o  (stall_nack_o),
    .active_o      (active_o),
    .rd_dep_o      (rd_dep_o),
    .wr_dep_o      (wr_dep_o),
    .wb_addr_o     (wb_addr_o)
  );

  // Request payload goes straight from the issue port
  apu_exec_unit apu_exec_unit_inst (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .req_i      (apu_req),
    .req_data_i (issue_req_i),
    .gnt_o      (apu_gnt),
    .resp_o     (apu_resp)
  );

  assign wb_valid_o = apu_resp.valid;
  assign wb_data_o  = apu_resp.result;

endmodule

//--- verilog/apu_exec_unit.sv
// Accelerator unit with add, multiply and multiply-add pipelines plus an iterative multiplier
`timescale 1ns/1ps

module apu_exec_unit (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               req_i,
  input  apu_pkg::apu_req_t  req_data_i,
  output logic               gnt_o,
  output apu_pkg::apu_resp_t resp_o
);

  import apu_pkg::*;

  logic        accept;

  // Class 1 add
  logic        add_vld_q;
  apu_data_t   add_res_q;

  // Class 2 multiply, split into partial products
  logic [1:0]  mul_vld_q;
  apu_data_t   mul_lo_q;
  logic [15:0] mul_hi_q;
  apu_data_t   mul_res_q;

  // Class 3 multiply-add
  logic [2:0]  mac_vld_q;
  apu_data_t   mac_prod_q;
  apu_data_t   mac_add_q;
  apu_data_t   mac_sum_q;
  apu_data_t   mac_res_q;

  // Class 0 shift-and-add engine
  iter_state_e iter_state_q, iter_state_d;
  apu_data_t   acc_q;
  apu_data_t   mcand_q;
  apu_data_t   mplier_q;

  // Grant only when asked and the engine is free
  assign gnt_o  = req_i & (iter_state_q == ITER_IDLE);
  assign accept = req_i & gnt_o;

  //////////////////////////////////////////////////
  // Fixed pipelines
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      add_vld_q <= 1'b0;
      mul_vld_q <= '0;
      mac_vld_q <= '0;
    end else begin
      add_vld_q <= accept & (req_data_i.lat == 2'd1);
      mul_vld_q <= {mul_vld_q[0], accept & (req_data_i.lat == 2'd2)};
      mac_vld_q <= {mac_vld_q[1:0], accept & (req_data_i.lat == 2'd3)};
    end
  end

  always_ff @(posedge clk_i) begin
    // Add, single stage
    add_res_q  <= req_data_i.op_a + req_data_i.op_b;

    // Multiply stage 1, low half of a times b and high half of a times low b
    mul_lo_q   <= req_data_i.op_a[15:0] * req_data_i.op_b;
    mul_hi_q   <= req_data_i.op_a[31:16] * req_data_i.op_b[15:0];
    // Stage 2, combine modulo 2^32
    mul_res_q  <= mul_lo_q + {mul_hi_q, 16'h0000};

    // Multiply-add stage 1, low halves product and high half of a as addend
    mac_prod_q <= req_data_i.op_a[15:0] * req_data_i.op_b[15:0];
    mac_add_q  <= {16'h0000, req_data_i.op_a[31:16]};
    // Stage 2 adds, stage 3 holds
    mac_sum_q  <= mac_prod_q + mac_add_q;
    mac_res_q  <= mac_sum_q;
  end

  //////////////////////////////////////////////////
  // Iterative multiplier
  //////////////////////////////////////////////////

  always_comb begin
    iter_state_d = iter_state_q;
    case (iter_state_q)
      ITER_IDLE: begin
        if (accept && (req_data_i.lat == 2'd0)) begin
          iter_state_d = ITER_RUN;
        end
      end
      ITER_RUN: begin
        // Last step when no set bit remains above bit 0
        if (mplier_q[31:1] == '0) begin
          iter_state_d = ITER_DONE;
        end
      end
      ITER_DONE: begin
        iter_state_d = ITER_IDLE;
      end
      default: begin
        iter_state_d = ITER_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      iter_state_q <= ITER_IDLE;
    end else begin
      iter_state_q <= iter_state_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if ((iter_state_q == ITER_IDLE) && accept && (req_data_i.lat == 2'd0)) begin
      acc_q    <= '0;
      mcand_q  <= req_data_i.op_a;
      mplier_q <= req_data_i.op_b;
    end else if (iter_state_q == ITER_RUN) begin
      // One multiplier bit per cycle
      if (mplier_q[0]) begin
        acc_q <= acc_q + mcand_q;
      end
      mcand_q  <= mcand_q << 1;
      mplier_q <= mplier_q >> 1;
    end
  end

  //////////////////////////////////////////////////
  // Response merge
  //////////////////////////////////////////////////

  // At most one source is valid per cycle
  always_comb begin
    resp_o.valid = add_vld_q | mul_vld_q[1] | mac_vld_q[2] | (iter_state_q == ITER_DONE);
    if (add_vld_q) begin
      resp_o.result = add_res_q;
    end else if (mul_vld_q[1]) begin
      resp_o.result = mul_res_q;
    end else if (mac_vld_q[2]) begin
      resp_o.result = mac_res_q;
    end else if (iter_state_q == ITER_DONE) begin
      resp_o.result = acc_q;
    end else begin
      resp_o.result = '0;
    end
  end

endmodule

//--- verilog/apu_dispatch.sv
// In-order issue dispatcher with slot tracking, hazard checks, stalls and write-back address
`timescale 1ns/1ps

module apu_dispatch #(
  parameter int NumRdPorts = 3,
  parameter int NumWrPorts = 2
) (
  input  logic                                  clk_i,
  input  logic                                  rst_ni,
  // Issue side
  input  logic                                  issue_en_i,
  input  apu_pkg::apu_lat_t                     lat_i,
  input  apu_pkg::reg_addr_t                    waddr_i,
  // Hazard probes from decode
  input  logic                                  is_decoding_i,
  input  apu_pkg::reg_addr_t [NumRdPorts-1:0]   rd_regs_i,
  input  logic               [NumRdPorts-1:0]   rd_valid_i,
  input  apu_pkg::reg_addr_t [NumWrPorts-1:0]   wr_regs_i,
  input  logic               [NumWrPorts-1:0]   wr_valid_i,
  // Unit link
  output logic                                  req_o,
  input  logic                                  gnt_i,
  input  logic                                  resp_valid_i,
  // Status toward the front end
  output logic                                  stall_o,
  output logic                                  stall_type_o,
  output logic                                  stall_nack_o,
  output logic                                  active_o,
  output logic                                  rd_dep_o,
  output logic                                  wr_dep_o,
  output apu_pkg::reg_addr_t                    wb_addr_o
);

  import apu_pkg::*;

  // In-flight slot holds the newest outstanding instruction
  // Waiting slot holds the older one
  logic      infl_vld_q, infl_vld_d;
  logic      wait_vld_q, wait_vld_d;
  reg_addr_t infl_addr_q, infl_addr_d;
  reg_addr_t wait_addr_q, wait_addr_d;
  apu_lat_t  lat_q;

  logic      valid_req;
  logic      req_accepted;
  logic      active;
  logic      returned_req, returned_infl, returned_wait;
  logic      stall_full, stall_type, stall_nack;

  logic [NumRdPorts-1:0] rd_hit_req, rd_hit_infl, rd_hit_wait;
  logic [NumWrPorts-1:0] wr_hit_req, wr_hit_infl, wr_hit_wait;
  logic                  rd_dep_req, rd_dep_infl, rd_dep_wait;
  logic                  wr_dep_req, wr_dep_infl, wr_dep_wait;

  //////////////////////////////////////////////////
  // Request and slot tracking
  //////////////////////////////////////////////////

  // Nack stalls still request, full and type stalls do not
  assign valid_req    = issue_en_i & ~(stall_full | stall_type);
  assign req_accepted = valid_req & gnt_i;
  assign active       = infl_vld_q | wait_vld_q;

  // Results return oldest first
  assign returned_wait = wait_vld_q & resp_valid_i;
  assign returned_infl = infl_vld_q & resp_valid_i & ~wait_vld_q;
  assign returned_req  = valid_req & resp_valid_i & ~infl_vld_q & ~wait_vld_q;

  always_comb begin
    infl_vld_d  = infl_vld_q;
    wait_vld_d  = wait_vld_q;
    infl_addr_d = infl_addr_q;
    wait_addr_d = wait_addr_q;

    // Retire the returning slot
    if (returned_wait) begin
      wait_vld_d = 1'b0;
    end else if (returned_infl) begin
      infl_vld_d = 1'b0;
    end

    // New instruction takes the in-flight slot
    if (req_accepted && !returned_req) begin
      // Older one still pending, so push it to waiting
      if (infl_vld_q && !returned_infl) begin
        wait_vld_d  = 1'b1;
        wait_addr_d = infl_addr_q;
      end
      infl_vld_d  = 1'b1;
      infl_addr_d = waddr_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      infl_vld_q <= 1'b0;
      wait_vld_q <= 1'b0;
      lat_q      <= '0;
    end else begin
      infl_vld_q <= infl_vld_d;
      wait_vld_q <= wait_vld_d;
      // Class of the last accepted instruction
      if (req_accepted) begin
        lat_q <= lat_i;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    infl_addr_q <= infl_addr_d;
    wait_addr_q <= wait_addr_d;
  end

  //////////////////////////////////////////////////
  // Hazard detection
  //////////////////////////////////////////////////

  always_comb begin
    for (int i = 0; i < NumRdPorts; i++) begin
      rd_hit_req[i]  = rd_valid_i[i] & (rd_regs_i[i] == waddr_i);
      rd_hit_infl[i] = rd_valid_i[i] & (rd_regs_i[i] == infl_addr_q);
      rd_hit_wait[i] = rd_valid_i[i] & (rd_regs_i[i] == wait_addr_q);
    end
    for (int i = 0; i < NumWrPorts; i++) begin
      wr_hit_req[i]  = wr_valid_i[i] & (wr_regs_i[i] == waddr_i);
      wr_hit_infl[i] = wr_valid_i[i] & (wr_regs_i[i] == infl_addr_q);
      wr_hit_wait[i] = wr_valid_i[i] & (wr_regs_i[i] == wait_addr_q);
    end
  end

  // A slot that writes back this cycle no longer blocks
  assign rd_dep_req  = (|rd_hit_req)  & valid_req  & ~returned_req;
  assign rd_dep_infl = (|rd_hit_infl) & infl_vld_q & ~returned_infl;
  assign rd_dep_wait = (|rd_hit_wait) & wait_vld_q & ~returned_wait;
  assign wr_dep_req  = (|wr_hit_req)  & valid_req  & ~returned_req;
  assign wr_dep_infl = (|wr_hit_infl) & infl_vld_q & ~returned_infl;
  assign wr_dep_wait = (|wr_hit_wait) & wait_vld_q & ~returned_wait;

  assign rd_dep_o = is_decoding_i & (rd_dep_req | rd_dep_infl | rd_dep_wait);
  assign wr_dep_o = is_decoding_i & (wr_dep_req | wr_dep_infl | wr_dep_wait);

  //////////////////////////////////////////////////
  // Stall generation
  //////////////////////////////////////////////////

  // Both slots taken and nothing leaves this cycle
  assign stall_full = infl_vld_q & wait_vld_q & ~returned_wait;

  // A new class must not return before the held one
  // Class 1 and iterative classes only issue when idle
  assign stall_type = issue_en_i & active &
                      ((lat_i == 2'd1) | (lat_i == 2'd0) | (lat_q == 2'd0) |
                       ((lat_q == 2'd3) & (lat_i == 2'd2)));

  // Unit refused the request
  assign stall_nack = valid_req & ~gnt_i;

  assign stall_o      = stall_full | stall_type | stall_nack;
  assign stall_type_o = stall_type;
  assign stall_nack_o = stall_nack;
  assign req_o        = valid_req;
  assign active_o     = active;

  // Write-back register of the returning slot, oldest wins
  always_comb begin
    wb_addr_o = '0;
    if (returned_wait) begin
      wb_addr_o = wait_addr_q;
    end else if (returned_infl) begin
      wb_addr_o = infl_addr_q;
    end else if (returned_req) begin
      wb_addr_o = waddr_i;
    end
  end

endmodule

//--- verilog/apu_pkg.sv
// Width typedefs, request and response structs, iterative engine state enum
package apu_pkg;

  // Register address of the core register file
  typedef logic [5:0]  reg_addr_t;

  // Operand and result word
  typedef logic [31:0] apu_data_t;

  // Latency class
  // 0 is iterative, 1 to 3 are fixed pipelines of that depth
  typedef logic [1:0]  apu_lat_t;

  // Request forwarded from the dispatcher to the unit, 66 bits
  typedef struct packed {
    apu_lat_t  lat;
    apu_data_t op_a;
    apu_data_t op_b;
  } apu_req_t;

  // Response with its one-cycle valid strobe, 33 bits
  typedef struct packed {
    logic      valid;
    apu_data_t result;
  } apu_resp_t;

  // Iterative multiplier states
  typedef enum logic [1:0] {
    ITER_IDLE,
    ITER_RUN,
    ITER_DONE
  } iter_state_e;

endpackage
